// File: logic/ics32_periph_settings.svh
// sizes and address map of the peripheral subsystem
// included by the packages and by every module that needs a width

`ifndef ICS32_PERIPH_SETTINGS_SVH
`define ICS32_PERIPH_SETTINGS_SVH

// bus address width and the bits that pick a region
`define ADDR_BITS 24
`define REGION_MSB 23
`define REGION_LSB 20

// cpu ram is 8192 words of 32 bits
`define RAM_WORDS 8192
`define RAM_ADDR_BITS 13

// red led lit out of reset
`define STATUS_RESET 2'b01

`define PAD_BITS 16

`endif

// File: logic/soc_bus_pkg.sv
// bus side types: master request, subsystem response and the
// select word that the decoder hands to the arbiter and peripherals

`include "ics32_periph_settings.svh"

package soc_bus_pkg;

    // region number is address bits 23:20
    typedef enum logic [3:0] {
        REGION_RAM    = 4'd0,
        REGION_STATUS = 4'd1,
        REGION_DSP    = 4'd2,
        REGION_PAD    = 4'd3,
        REGION_IRQ    = 4'd4,
        REGION_NONE   = 4'hf
    } region_e;

    // nonzero wstrb marks a write
    typedef struct packed {
        logic [`ADDR_BITS-1:0] address;
        logic                  valid;
        logic [3:0]            wstrb;
        logic [31:0]           write_data;
    } bus_req_t;

    typedef struct packed {
        logic        ready;
        logic [31:0] read_data;
    } bus_rsp_t;

    // word is address bit 2
    typedef struct packed {
        region_e region;
        logic    en;
        logic    write;
        logic    word;
    } periph_sel_t;

endpackage

// File: logic/soc_periph_pkg.sv
// peripheral side types: decoder states, gamepad control bits
// and the interrupt bit layout

package soc_periph_pkg;

    typedef enum logic [1:0] {
        DEC_IDLE = 2'd0,
        DEC_WAIT = 2'd1,
        DEC_DONE = 2'd2
    } dec_state_e;

    // latch is data bit 0, clk is data bit 1
    typedef struct packed {
        logic clk;
        logic latch;
    } pad_ctrl_t;

    // frame is bit 0, raster is bit 1
    typedef struct packed {
        logic raster;
        logic frame;
    } irq_bits_t;

endpackage

// File: logic/address_decoder.sv
// registers each bus request and issues one select pulse for its region
// the request stays registered until the master drops valid

`timescale 1ns/1ps
`include "ics32_periph_settings.svh"

module address_decoder import soc_bus_pkg::*, soc_periph_pkg::*; (
    input  logic                  vdp_clk,
    input  logic                  vdp_reset,
    input  bus_req_t              bus_req,
    input  logic                  ready,
    output periph_sel_t           sel,
    output logic [`ADDR_BITS-1:0] address,
    output logic [31:0]           write_data,
    output logic [3:0]            wstrb
);
    bus_req_t   req_r;
    dec_state_e state;
    logic       sel_en;
    region_e    sel_region;
    logic       sel_write;
    logic       sel_word;

    function automatic region_e decode_region(input logic [3:0] bits);
        case (bits)
            4'd0:    decode_region = REGION_RAM;
            4'd1:    decode_region = REGION_STATUS;
            4'd2:    decode_region = REGION_DSP;
            4'd3:    decode_region = REGION_PAD;
            4'd4:    decode_region = REGION_IRQ;
            default: decode_region = REGION_NONE;
        endcase
    endfunction

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            req_r <= '0;
            state <= DEC_IDLE;
            sel_en <= 1'b0;
        end else begin
            req_r <= bus_req;
            sel_en <= 1'b0;

            case (state)
                DEC_IDLE: begin
                    if (req_r.valid) begin
                        sel_en <= 1'b1;
                        state <= DEC_WAIT;
                    end
                end
                DEC_WAIT: begin
                    if (ready) begin
                        state <= DEC_DONE;
                    end
                end
                // hold off until the master has dropped valid
                DEC_DONE: begin
                    if (!req_r.valid) begin
                        state <= DEC_IDLE;
                    end
                end
                default: state <= DEC_IDLE;
            endcase
        end
    end

    // select fields follow the registered request every cycle
    always_ff @(posedge vdp_clk) begin
        sel_region <= decode_region(req_r.address[`REGION_MSB:`REGION_LSB]);
        sel_write <= |req_r.wstrb;
        sel_word <= req_r.address[2];
    end

    assign sel = '{region: sel_region, en: sel_en, write: sel_write, word: sel_word};

    assign address = req_r.address;
    assign write_data = req_r.write_data;
    assign wstrb = req_r.wstrb;

    // one pulse per request, never back to back
    assert property (@(posedge vdp_clk) disable iff (vdp_reset) sel.en |=> !sel.en);

endmodule

// File: logic/bus_arbiter.sv
// drives the cpu ram port and answers each select with a one cycle ready
// read data of the selected region is captured on the same edge

`timescale 1ns/1ps
`include "ics32_periph_settings.svh"

module bus_arbiter import soc_bus_pkg::*; (
    input  logic                      vdp_clk,
    input  logic                      vdp_reset,

    input  periph_sel_t               sel,
    input  logic [`ADDR_BITS-1:0]     address,
    input  logic [31:0]               write_data,
    input  logic [3:0]                wstrb,

    input  logic [31:0]               ram_read_data,
    input  logic [31:0]               aux_read_data,
    input  logic [31:0]               pad_read_data,
    input  logic [31:0]               irq_read_data,

    output logic                      ram_cs,
    output logic [`RAM_ADDR_BITS-1:0] ram_address,
    output logic [3:0]                ram_wstrb,
    output logic [31:0]               ram_write_data,

    output bus_rsp_t                  bus_rsp
);
    logic        ready_r;
    logic [31:0] read_data_r;
    logic [31:0] read_mux;

    // ram only sees a write during the select pulse
    assign ram_cs = sel.en && (sel.region == REGION_RAM);
    assign ram_wstrb = (ram_cs && sel.write) ? wstrb : 4'b0000;
    assign ram_address = address[`RAM_ADDR_BITS+1:2];
    assign ram_write_data = write_data;

    always_comb begin
        case (sel.region)
            REGION_RAM:    read_mux = ram_read_data;
            REGION_STATUS: read_mux = aux_read_data;
            REGION_DSP:    read_mux = aux_read_data;
            REGION_PAD:    read_mux = pad_read_data;
            REGION_IRQ:    read_mux = irq_read_data;
            // unmapped reads return zero
            default:       read_mux = 32'h0;
        endcase
    end

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            ready_r <= 1'b0;
        end else begin
            ready_r <= sel.en;
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (sel.en) begin
            read_data_r <= read_mux;
        end
    end

    assign bus_rsp = '{ready: ready_r, read_data: read_data_r};

    // every ready answers a single select pulse from the decoder
    assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        bus_rsp.ready |-> $past(sel.en) && !$past(sel.en, 2));

endmodule

// File: logic/cpu_ram.sv
// cpu work ram, 32 bit words with per byte write enables
// reads are synchronous and follow the address every cycle

`timescale 1ns/1ps
`include "ics32_periph_settings.svh"

module cpu_ram (
    input  logic                      vdp_clk,
    input  logic                      cs,
    input  logic [`RAM_ADDR_BITS-1:0] address,
    input  logic [3:0]                wstrb,
    input  logic [31:0]               write_data,
    output logic [31:0]               read_data
);
    logic [31:0] mem [0:`RAM_WORDS-1];

    always_ff @(posedge vdp_clk) begin
        for (int i = 0; i < 4; i++) begin
            if (cs && wstrb[i]) begin
                mem[address][i*8 +: 8] <= write_data[i*8 +: 8];
            end
        end

        // old data on a same cycle write
        read_data <= mem[address];
    end

endmodule

// File: logic/aux_regs.sv
// status led register and the signed 16x16 multiplier
// operand a is word 0, operand b is word 1, reads return the product

`timescale 1ns/1ps
`include "ics32_periph_settings.svh"

module aux_regs import soc_bus_pkg::*; (
    input  logic        vdp_clk,
    input  logic        vdp_reset,
    input  periph_sel_t sel,
    input  logic [31:0] write_data,
    output logic [1:0]  status,
    output logic [31:0] read_data
);
    logic               status_write;
    logic               dsp_write;
    logic signed [15:0] mult_a;
    logic signed [15:0] mult_b;
    logic signed [31:0] product;

    assign status_write = sel.en && sel.write && (sel.region == REGION_STATUS);
    assign dsp_write = sel.en && sel.write && (sel.region == REGION_DSP);

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            status <= `STATUS_RESET;
        end else if (status_write) begin
            status <= write_data[1:0];
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (dsp_write && !sel.word) begin
            mult_a <= write_data[15:0];
        end
        if (dsp_write && sel.word) begin
            mult_b <= write_data[15:0];
        end

        // product lags the operands by one cycle
        product <= mult_a * mult_b;
    end

    assign read_data = (sel.region == REGION_STATUS) ? {30'h0, status} : product;

endmodule

// File: logic/pad_reader.sv
// gamepad reader backed by the three board buttons
// software raises latch to load, then toggles clk to shift bits out

`timescale 1ns/1ps
`include "ics32_periph_settings.svh"

module pad_reader import soc_bus_pkg::*, soc_periph_pkg::*; (
    input  logic        vdp_clk,
    input  logic        vdp_reset,
    input  periph_sel_t sel,
    input  logic [31:0] write_data,
    input  logic [2:0]  btn,
    output logic [31:0] read_data
);
    pad_ctrl_t              ctrl;
    logic                   pad_clk_r;
    logic [`PAD_BITS-1:0]   shift;

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            ctrl <= '0;
            pad_clk_r <= 1'b0;
        end else begin
            if (sel.en && sel.write && (sel.region == REGION_PAD)) begin
                ctrl <= write_data[1:0];
            end
            pad_clk_r <= ctrl.clk;
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            shift <= '0;
        end else begin
            // btn2 is B, btn1 left, btn3 right
            if (ctrl.latch) begin
                shift <= {8'h00, btn[2], btn[0], 5'b00000, btn[1]};
            end
            // rising edge of the pad clock wins over a load
            if (ctrl.clk && !pad_clk_r) begin
                shift <= {1'b0, shift[`PAD_BITS-1:1]};
            end
        end
    end

    assign read_data = {31'h0, shift[0]};

endmodule

// File: logic/cpu_irq_control.sv
// pending latches for the frame end and raster hit interrupts
// a write to the irq region acknowledges the bits set in the data

`timescale 1ns/1ps

module cpu_irq_control import soc_bus_pkg::*, soc_periph_pkg::*; (
    input  logic        vdp_clk,
    input  logic        vdp_reset,
    input  logic        frame_end,
    input  logic        raster_hit,
    input  periph_sel_t sel,
    input  logic [31:0] write_data,
    output irq_bits_t   irq,
    output logic [31:0] read_data
);
    irq_bits_t pending;
    irq_bits_t ack;

    assign ack = (sel.en && sel.write && (sel.region == REGION_IRQ)) ?
                 write_data[1:0] : 2'b00;

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            pending <= '0;
        end else begin
            // a new request beats an acknowledge in the same cycle
            pending.frame <= frame_end || (pending.frame && !ack.frame);
            pending.raster <= raster_hit || (pending.raster && !ack.raster);
        end
    end

    assign irq = pending;
    assign read_data = {30'h0, pending};

    assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        $fell(pending.frame) |-> $past(ack.frame));
    assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        $fell(pending.raster) |-> $past(ack.raster));

endmodule

// File: logic/ics32_periph.sv
// peripheral subsystem top, everything on vdp_clk
// the bus master sees one request and response port

`timescale 1ns/1ps
`include "ics32_periph_settings.svh"

module ics32_periph import soc_bus_pkg::*, soc_periph_pkg::*; (
    input  logic       vdp_clk,
    input  logic       vdp_reset,
    input  bus_req_t   bus_req,
    input  logic [2:0] btn,
    input  logic       frame_end,
    input  logic       raster_hit,
    output bus_rsp_t   bus_rsp,
    output logic       led_r,
    output logic       led_b,
    output irq_bits_t  irq
);
    periph_sel_t               sel;
    logic [`ADDR_BITS-1:0]     address;
    logic [31:0]               write_data;
    logic [3:0]                wstrb;

    logic                      ram_cs;
    logic [`RAM_ADDR_BITS-1:0] ram_address;
    logic [3:0]                ram_wstrb;
    logic [31:0]               ram_write_data;
    logic [31:0]               ram_read_data;

    logic [31:0]               aux_read_data;
    logic [31:0]               pad_read_data;
    logic [31:0]               irq_read_data;
    logic [1:0]                status;

    assign led_r = status[0];
    assign led_b = status[1];

    address_decoder decoder (
        .vdp_clk(vdp_clk), .vdp_reset(vdp_reset), .bus_req(bus_req),
        .ready(bus_rsp.ready), .sel(sel), .address(address),
        .write_data(write_data), .wstrb(wstrb)
    );

    bus_arbiter arbiter (
        .vdp_clk(vdp_clk), .vdp_reset(vdp_reset), .sel(sel), .address(address),
        .write_data(write_data), .wstrb(wstrb),
        .ram_read_data(ram_read_data), .aux_read_data(aux_read_data),
        .pad_read_data(pad_read_data), .irq_read_data(irq_read_data),
        .ram_cs(ram_cs), .ram_address(ram_address), .ram_wstrb(ram_wstrb),
        .ram_write_data(ram_write_data), .bus_rsp(bus_rsp)
    );

    cpu_ram ram (
        .vdp_clk(vdp_clk), .cs(ram_cs), .address(ram_address), .wstrb(ram_wstrb),
        .write_data(ram_write_data), .read_data(ram_read_data)
    );

    aux_regs aux (
        .vdp_clk(vdp_clk), .vdp_reset(vdp_reset), .sel(sel),
        .write_data(write_data), .status(status), .read_data(aux_read_data)
    );

    pad_reader pad (
        .vdp_clk(vdp_clk), .vdp_reset(vdp_reset), .sel(sel),
        .write_data(write_data), .btn(btn), .read_data(pad_read_data)
    );

    cpu_irq_control irq_control (
        .vdp_clk(vdp_clk), .vdp_reset(vdp_reset), .frame_end(frame_end),
        .raster_hit(raster_hit), .sel(sel), .write_data(write_data),
        .irq(irq), .read_data(irq_read_data)
    );

endmodule

// File: testbench/tb_ics32_periph.sv
// directed testbench for the peripheral subsystem
// drives bus requests on falling edges and checks data, leds and irq

`timescale 1ns/1ps
`include "ics32_periph_settings.svh"

module tb_ics32_periph import soc_bus_pkg::*, soc_periph_pkg::*; ();
    localparam logic [`ADDR_BITS-1:0] STATUS_ADDR = 24'h100000;
    localparam logic [`ADDR_BITS-1:0] DSP_ADDR = 24'h200000;
    localparam logic [`ADDR_BITS-1:0] PAD_ADDR = 24'h300000;
    localparam logic [`ADDR_BITS-1:0] IRQ_ADDR = 24'h400000;
    localparam logic [`ADDR_BITS-1:0] NONE_ADDR = 24'h700000;
    localparam int REQ_LIMIT = 16;
    localparam int CYCLE_LIMIT = 4000;

    logic       vdp_clk = 1'b0;
    logic       vdp_reset;
    bus_req_t   bus_req;
    logic [2:0] btn;
    logic       frame_end;
    logic       raster_hit;
    bus_rsp_t   bus_rsp;
    logic       led_r;
    logic       led_b;
    irq_bits_t  irq;

    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;
    logic [31:0] rng_state = 32'hf718_218f;

    ics32_periph DUT (
        .vdp_clk(vdp_clk), .vdp_reset(vdp_reset), .bus_req(bus_req), .btn(btn),
        .frame_end(frame_end), .raster_hit(raster_hit), .bus_rsp(bus_rsp),
        .led_r(led_r), .led_b(led_b), .irq(irq)
    );

    always #2 vdp_clk = ~vdp_clk;

    // hard stop in case a request never completes
    always @(posedge vdp_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles without reaching the end", CYCLE_LIMIT);
            $display("Errors found");
            $finish;
        end
    end

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    task automatic report_error(input string msg);
        error_count++;
        $display("%s", msg);
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("FAIL %s: got %h expected %h", name, got, expected);
        end
    endtask

    task automatic check_leds(input logic [1:0] got, input logic [1:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("FAIL {led_b, led_r}: got %h expected %h", got, expected);
        end
    endtask

    task automatic check_irq(input irq_bits_t got, input irq_bits_t expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("FAIL irq: got %h expected %h", got, expected);
        end
    endtask

    // one request, ready must come on the third falling edge and last one cycle
    task automatic send_request(input logic [`ADDR_BITS-1:0] addr, input logic [31:0] data,
                                input logic [3:0] strb, output logic [31:0] read_data);
        int waited;
        waited = 0;
        bus_req = '{address: addr, valid: 1'b1, wstrb: strb, write_data: data};
        do begin
            @(negedge vdp_clk);
            waited++;
        end while (!bus_rsp.ready && waited < REQ_LIMIT);
        read_data = bus_rsp.read_data;
        if (!bus_rsp.ready) begin
            report_error($sformatf("no ready within %0d cycles at address %h", REQ_LIMIT, addr));
        end else if (waited != 3) begin
            report_error($sformatf("ready came after %0d cycles instead of 3", waited));
        end
        bus_req = '0;
        @(negedge vdp_clk);
        if (bus_rsp.ready) begin
            report_error("ready stayed high for more than one cycle");
        end
        @(negedge vdp_clk);
    endtask

    task automatic bus_write(input logic [`ADDR_BITS-1:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
        logic [31:0] unused;
        send_request(addr, data, strb, unused);
    endtask

    task automatic bus_read(input logic [`ADDR_BITS-1:0] addr, output logic [31:0] data);
        send_request(addr, 32'h0, 4'h0, data);
    endtask

    task automatic status_leds();
        logic [31:0] r;
        logic [31:0] rd;
        check_leds({led_b, led_r}, 2'b01);
        check_irq(irq, 2'b00);
        for (int i = 0; i < 4; i++) begin
            r = next_random();
            bus_write(STATUS_ADDR, r, 4'hf);
            check_leds({led_b, led_r}, r[1:0]);
            bus_read(STATUS_ADDR, rd);
            check_word("status read_data", rd, {30'h0, r[1:0]});
        end
    endtask

    task automatic ram_byte_merge();
        logic [`ADDR_BITS-1:0] addrs [16];
        logic [31:0]           model [16];
        logic [31:0]           r;
        logic [31:0]           rd;
        logic [3:0]            strb;
        // low word bits carry the index so addresses never repeat
        for (int i = 0; i < 16; i++) begin
            r = next_random();
            addrs[i] = {9'h0, r[12:4], i[3:0], 2'b00};
            model[i] = next_random();
            bus_write(addrs[i], model[i], 4'hf);
        end
        for (int i = 0; i < 16; i += 2) begin
            strb = 4'b0001 << (i / 2 % 4);
            r = next_random();
            bus_write(addrs[i], r, strb);
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    model[i][b*8 +: 8] = r[b*8 +: 8];
                end
            end
        end
        for (int i = 0; i < 16; i++) begin
            bus_read(addrs[i], rd);
            check_word("ram read_data", rd, model[i]);
        end
    endtask

    task automatic dsp_signed_product();
        logic signed [15:0] a;
        logic signed [15:0] b;
        logic signed [31:0] expected;
        logic [31:0]        r;
        logic [31:0]        rd;
        for (int i = 0; i < 6; i++) begin
            r = next_random();
            a = r[15:0];
            b = r[31:16];
            if (i % 2 == 0) a[15] = 1'b1;
            if (i % 3 == 0) b[15] = 1'b1;
            expected = a * b;
            // upper data bits are junk that the multiplier must ignore
            bus_write(DSP_ADDR, {r[31:16], a}, 4'hf);
            bus_write(DSP_ADDR + 24'h4, {r[15:0], b}, 4'hf);
            bus_read(DSP_ADDR, rd);
            check_word("dsp product", rd, expected);
        end
    endtask

    task automatic pad_shift_out(input logic [2:0] pattern);
        logic [15:0] layout;
        logic [31:0] rd;
        layout = '0;
        layout[0] = pattern[1];
        layout[6] = pattern[0];
        layout[7] = pattern[2];
        btn = pattern;
        bus_write(PAD_ADDR, 32'h1, 4'hf);
        bus_write(PAD_ADDR, 32'h0, 4'hf);
        for (int i = 0; i < 12; i++) begin
            bus_read(PAD_ADDR, rd);
            check_word("pad read_data", rd, {31'h0, layout[i]});
            bus_write(PAD_ADDR, 32'h2, 4'hf);
            bus_write(PAD_ADDR, 32'h0, 4'hf);
        end
    endtask

    task automatic irq_pending_ack();
        logic [31:0] rd;
        frame_end = 1'b1;
        @(negedge vdp_clk);
        frame_end = 1'b0;
        check_irq(irq, 2'b01);
        raster_hit = 1'b1;
        @(negedge vdp_clk);
        raster_hit = 1'b0;
        check_irq(irq, 2'b11);
        bus_read(IRQ_ADDR, rd);
        check_word("irq read_data", rd, 32'h3);
        bus_write(IRQ_ADDR, 32'h1, 4'hf);
        check_irq(irq, 2'b10);
        bus_read(IRQ_ADDR, rd);
        check_word("irq read_data", rd, 32'h2);
        bus_write(IRQ_ADDR, 32'h2, 4'hf);
        check_irq(irq, 2'b00);
    endtask

    task automatic unmapped_region();
        logic [31:0] rd;
        bus_write(24'h000040, 32'h5a5a_a5a5, 4'hf);
        // leds and a pending raster bit that an all ones write would disturb
        bus_write(STATUS_ADDR, 32'h2, 4'hf);
        raster_hit = 1'b1;
        @(negedge vdp_clk);
        raster_hit = 1'b0;
        bus_read(NONE_ADDR | 24'h40, rd);
        check_word("unmapped read_data", rd, 32'h0);
        bus_write(NONE_ADDR | 24'h40, 32'hffff_ffff, 4'hf);
        check_leds({led_b, led_r}, 2'b10);
        check_irq(irq, 2'b10);
        bus_read(24'h000040, rd);
        check_word("ram read_data", rd, 32'h5a5a_a5a5);
    endtask

    initial begin
        vdp_reset = 1'b1;
        bus_req = '0;
        btn = 3'b000;
        frame_end = 1'b0;
        raster_hit = 1'b0;
        repeat (16) @(negedge vdp_clk);
        vdp_reset = 1'b0;
        @(negedge vdp_clk);

        status_leds();
        ram_byte_merge();
        dsp_signed_product();
        pad_shift_out(3'b011);
        pad_shift_out(3'b101);
        irq_pending_ack();
        unmapped_region();

        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: ics32_periph.f
+incdir+logic
logic/soc_bus_pkg.sv
logic/soc_periph_pkg.sv
logic/address_decoder.sv
logic/bus_arbiter.sv
logic/cpu_ram.sv
logic/aux_regs.sv
logic/pad_reader.sv
logic/cpu_irq_control.sv
logic/ics32_periph.sv
testbench/tb_ics32_periph.sv

// File: Makefile
TOP = tb_ics32_periph

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f ics32_periph.f --top-module $(TOP)

# the run fails unless the pass line shows up in the simulator output
run: compile
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir
